// File: Makefile
TOOL = verilator
FLAGS = --binary --timing -j 0
TOP = face_detect_top_tb
FILELIST = face_detect_top.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_TEXT = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: face_detect_top.f
fd_frame_pkg.sv
fd_classifier_pkg.sv
haar_database.sv
scale_inspector.sv
result_buffer.sv
face_detect_top.sv
face_detect_top_tb.sv

// File: face_detect_top.sv
`timescale 1ns/1ns
`default_nettype none

module face_detect_top import fd_frame_pkg::*, fd_classifier_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire pixel_t i_pixel,
	input wire logic i_pixel_valid,
	output logic o_ready,
	output logic o_inspect,
	output hit_t o_hit,
	output logic o_hit_valid,
	output logic o_frame_done,
	output result_count_t o_hit_count
);

	typedef enum logic [1:0]
	{
		S_RECEIVE,
		S_INSPECT,
		S_END_FRAME
	} state_t;

	state_t state;
	state_t state_next;
	coord_t cur_x;
	coord_t cur_y;
	stage_bus_t stage_bus;
	scale_mask_t candidates;
	hit_t hit_rec;
	logic accept;
	logic last_pixel;
	logic leave;
	logic db_start;
	logic eval; // Candidate bits are valid
	logic hit_write;
	logic read_start;
	logic buf_done;

	always_comb
	begin
		accept = o_ready && i_pixel_valid;
		last_pixel = (cur_x == coord_t'(FRAME_WIDTH - 1)) && (cur_y == coord_t'(FRAME_HEIGHT - 1));
		leave = (state == S_INSPECT) && ((eval && (candidates == '0)) || hit_write);
		o_inspect = state == S_INSPECT;
		o_frame_done = (state == S_END_FRAME) && buf_done;
	end

	assign hit_rec = '{x: cur_x, y: cur_y, scale: candidates};

	always_comb
	begin
		state_next = state;
		case (state)
			S_RECEIVE:
				if (accept)
					state_next = S_INSPECT;
			S_INSPECT:
				if (leave)
					state_next = last_pixel ? S_END_FRAME : S_RECEIVE;
			S_END_FRAME:
				if (buf_done)
					state_next = S_RECEIVE;
			default:
				state_next = S_RECEIVE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_RECEIVE;
			o_ready <= 1'b0;
			db_start <= 1'b0;
			eval <= 1'b0;
			hit_write <= 1'b0;
			read_start <= 1'b0;
			cur_x <= '0;
			cur_y <= '0;
		end
		else
		begin
			state <= state_next;
			o_ready <= state_next == S_RECEIVE;
			db_start <= accept; // Database pass starts one cycle later
			eval <= stage_bus.last;
			hit_write <= eval && (candidates != '0);
			read_start <= (state == S_INSPECT) && (state_next == S_END_FRAME);
			// Coordinate stays on the pixel until its inspection is over
			if (leave)
			begin
				if (cur_x == coord_t'(FRAME_WIDTH - 1))
				begin
					cur_x <= '0;
					if (cur_y == coord_t'(FRAME_HEIGHT - 1))
						cur_y <= '0;
					else
						cur_y <= cur_y + 1'b1;
				end
				else
					cur_x <= cur_x + 1'b1;
			end
		end
	end

	for (genvar s = 0; s < NUM_SCALES; s++)
	begin : g_scale
		scale_inspector u_inspector
		(
			.clk(clk),
			.reset(reset),
			.i_new_frame(o_frame_done),
			.i_accept(accept),
			.i_pixel(i_pixel),
			.i_x(cur_x),
			.i_y(cur_y),
			.i_stage(stage_bus),
			.i_scale_shift(stage_index_t'(s)), // Step is 2^s
			.o_candidate(candidates[s])
		);
	end

	haar_database u_database
	(
		.clk(clk),
		.reset(reset),
		.i_start(db_start),
		.o_stage(stage_bus)
	);

	result_buffer u_results
	(
		.clk(clk),
		.reset(reset),
		.i_clear(o_frame_done),
		.i_write(hit_write),
		.i_hit(hit_rec),
		.i_read_start(read_start),
		.o_hit(o_hit),
		.o_hit_valid(o_hit_valid),
		.o_done(buf_done),
		.o_count(o_hit_count)
	);

endmodule

`default_nettype wire

// File: face_detect_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module face_detect_top_tb import fd_frame_pkg::*, fd_classifier_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int NUM_FRAMES = 3;
	localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
	localparam int TOTAL_PIXELS = NUM_FRAMES * FRAME_PIXELS;
	localparam int CYCLES_PER_PIXEL = NUM_STAGES + 3 + 8; // Inspection plus stalls on low valid
	localparam int WATCHDOG_NS = NUM_FRAMES * (FRAME_PIXELS * CYCLES_PER_PIXEL
		+ RESULT_DEPTH + 4) * CLK_PERIOD;
	localparam logic [15:0] LFSR_SEED = 16'd34868;

	logic clk = 1'b0;
	logic reset = 1'b1;
	pixel_t i_pixel = '0;
	logic i_pixel_valid = 1'b0;
	logic o_ready;
	logic o_inspect;
	hit_t o_hit;
	logic o_hit_valid;
	logic o_frame_done;
	result_count_t o_hit_count;

	logic [15:0] lfsr_state = LFSR_SEED;
	logic stimulus_on = 1'b0;
	int reset_cycles = 0;
	int generated = 0; // Pixels put on the input so far
	int accepted = 0;

	// Reference model state
	int model_x = 0;
	int model_y = 0;
	int model_taps [NUM_SCALES][WINDOW_TAPS];
	int model_fill [NUM_SCALES];
	hit_t expected_hits [$];
	int stored_hits = 0;
	int frame_pixels = 0;
	int frames_done = 0;
	logic frame_end_due = 1'b0;
	logic busy = 1'b0;
	int low_cycles = 0;
	int expected_low = 0;
	int inspect_cycles = 0; // Cycles of o_inspect high for the current pixel

	face_detect_top UUT
	(
		.clk(clk),
		.reset(reset),
		.i_pixel(i_pixel),
		.i_pixel_valid(i_pixel_valid),
		.o_ready(o_ready),
		.o_inspect(o_inspect),
		.o_hit(o_hit),
		.o_hit_valid(o_hit_valid),
		.o_frame_done(o_frame_done),
		.o_hit_count(o_hit_count)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	function automatic logic [7:0] random_bits(input int count);
		logic [7:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[6:0], lfsr_state[0]};
		end
		return value;
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("error in %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	function automatic logic window_passes(input int s);
		int score;
		for (int k = 0; k < NUM_STAGES; k++)
		begin
			score = 0;
			for (int i = 0; i < WINDOW_TAPS; i++)
				score += int'($signed(STAGE_TABLE[k].weights[i])) * model_taps[s][i];
			if (score < int'(STAGE_TABLE[k].threshold))
				return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic model_pixel(input int pix);
		scale_mask_t mask;
		hit_t h;
		logic last;
		mask = '0;
		for (int s = 0; s < NUM_SCALES; s++)
		begin
			if ((model_x % (1 << s)) == 0 && (model_y % (1 << s)) == 0)
			begin
				if (model_x == 0)
				begin
					for (int i = 0; i < WINDOW_TAPS; i++)
						model_taps[s][i] = 0;
					model_fill[s] = 0; // New row
				end
				for (int i = WINDOW_TAPS - 1; i > 0; i--)
					model_taps[s][i] = model_taps[s][i-1];
				model_taps[s][0] = pix;
				if (model_fill[s] < WINDOW_TAPS)
					model_fill[s]++;
				if (model_fill[s] == WINDOW_TAPS && window_passes(s))
					mask[s] = 1'b1;
			end
		end
		last = (model_x == FRAME_WIDTH - 1) && (model_y == FRAME_HEIGHT - 1);
		if (mask != '0 && stored_hits < RESULT_DEPTH)
		begin
			h.x = coord_t'(model_x);
			h.y = coord_t'(model_y);
			h.scale = mask;
			expected_hits.push_back(h);
			stored_hits++;
		end
		inspect_cycles = (mask != '0) ? NUM_STAGES + 3 : NUM_STAGES + 2;
		expected_low = inspect_cycles;
		if (last)
		begin
			expected_low += stored_hits + 2; // Readout start, replay, done
			frame_end_due = 1'b1;
		end
		busy = 1'b1;
		low_cycles = 0;
		frame_pixels++;
		accepted++;
		if (model_x == FRAME_WIDTH - 1)
		begin
			model_x = 0;
			model_y = (model_y == FRAME_HEIGHT - 1) ? 0 : model_y + 1;
		end
		else
			model_x++;
	endtask

	task automatic end_of_frame();
		if (!frame_end_due)
		begin
			$display("Frame done pulse came before the frame was complete");
			abort_run();
		end
		compare("hits left unreplayed", 32'(0), 32'(expected_hits.size()));
		compare("stored hit count", 32'(stored_hits), 32'(o_hit_count));
		compare("pixels in frame", 32'(FRAME_PIXELS), 32'(frame_pixels));
		if (frames_done == 0)
			compare("bright frame overflow", 32'(RESULT_DEPTH), 32'(o_hit_count));
		for (int s = 0; s < NUM_SCALES; s++)
			model_fill[s] = 0;
		stored_hits = 0;
		frame_pixels = 0;
		frame_end_due = 1'b0;
		frames_done++;
	endtask

	// Runs at the falling edge, where all DUT outputs are settled
	task automatic monitor_cycle();
		hit_t h;
		if (busy)
		begin
			if (o_ready)
			begin
				compare("ready low cycles", 32'(expected_low), 32'(low_cycles));
				busy = 1'b0;
			end
			else
			begin
				compare("inspect level", 32'(low_cycles < inspect_cycles), 32'(o_inspect));
				low_cycles++;
			end
		end
		else
			compare("inspect level", 32'(0), 32'(o_inspect));
		if (o_ready && i_pixel_valid)
			model_pixel(int'(i_pixel));
		if (o_hit_valid)
		begin
			if (expected_hits.size() == 0)
			begin
				$display("A hit was replayed that the model did not expect");
				abort_run();
			end
			h = expected_hits.pop_front();
			compare("hit x", 32'(h.x), 32'(o_hit.x));
			compare("hit y", 32'(h.y), 32'(o_hit.y));
			compare("hit scale mask", 32'(h.scale), 32'(o_hit.scale));
		end
		if (o_frame_done)
			end_of_frame();
	endtask

	always @(posedge clk)
	begin
		reset <= reset_cycles < 2;
		if (reset_cycles < 3)
			reset_cycles = reset_cycles + 1;
		if (stimulus_on)
		begin
			// Next pixel only once the previous one was taken
			if (generated == accepted && generated < TOTAL_PIXELS)
			begin
				if (generated < FRAME_PIXELS)
					i_pixel <= 8'hFF;
				else
					i_pixel <= random_bits(8);
				generated = generated + 1;
			end
			i_pixel_valid <= (generated > accepted) && (random_bits(4) < 8'd11);
		end
	end

	initial
	begin
		repeat (3) @(posedge clk);
		@(negedge clk);
		compare("ready low after reset", 32'(0), 32'(o_ready));
		compare("hit valid low after reset", 32'(0), 32'(o_hit_valid));
		compare("frame done low after reset", 32'(0), 32'(o_frame_done));
		compare("inspect low after reset", 32'(0), 32'(o_inspect));
		@(negedge clk);
		compare("ready rises after reset", 32'(1), 32'(o_ready));
		stimulus_on = 1'b1;
		while (frames_done < NUM_FRAMES)
		begin
			@(negedge clk);
			monitor_cycle();
		end
		if (accepted == TOTAL_PIXELS)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			$display("Run ended with %0d of %0d pixels accepted", accepted, TOTAL_PIXELS);
			abort_run();
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the frames did not complete within %0d ns", WATCHDOG_NS);
		abort_run();
	end

endmodule

`default_nettype wire

// File: fd_classifier_pkg.sv
`default_nettype none

package fd_classifier_pkg;

	localparam int NUM_STAGES = 4;
	localparam int WINDOW_TAPS = 4;

	typedef logic signed [1:0] weight_t; // -2 .. +1
	typedef logic signed [11:0] score_t; // Worst case -2040 .. +1020
	typedef logic [1:0] stage_index_t;

	// weights[0] applies to the newest tap
	typedef struct packed
	{
		weight_t [WINDOW_TAPS-1:0] weights;
		score_t threshold;
	} stage_entry_t;

	typedef struct packed
	{
		stage_entry_t entry;
		logic valid;
		logic last; // Final entry of a pass
	} stage_bus_t;

	// Three orthogonal edge patterns and one brightness stage.
	// Each edge stage passes about two thirds of random windows and the
	// brightness stage about a third, so roughly one window in ten survives.
	localparam stage_entry_t STAGE_TABLE [NUM_STAGES] = '{
		'{weights: 8'b11_01_11_01, threshold: -12'sd60}, // + - + -
		'{weights: 8'b11_11_01_01, threshold: -12'sd60}, // + + - -
		'{weights: 8'b01_11_11_01, threshold: -12'sd60}, // + - - +
		'{weights: 8'b01_01_01_01, threshold: 12'sd580} // Mean brightness
	};

endpackage

`default_nettype wire

// File: fd_frame_pkg.sv
`default_nettype none

package fd_frame_pkg;

	localparam int FRAME_WIDTH = 20;
	localparam int FRAME_HEIGHT = 15;
	localparam int NUM_SCALES = 3; // Steps 1, 2 and 4
	localparam int RESULT_DEPTH = 16;
	localparam int RESULT_ADDR_WIDTH = $clog2(RESULT_DEPTH);

	typedef logic [7:0] pixel_t; // Grey value
	typedef logic [4:0] coord_t; // x or y
	typedef logic [NUM_SCALES-1:0] scale_mask_t; // One bit per scale
	typedef logic [4:0] result_count_t; // 0 .. RESULT_DEPTH
	typedef logic [RESULT_ADDR_WIDTH-1:0] result_addr_t;

	// One detection as stored and replayed by the result buffer
	typedef struct packed
	{
		coord_t x;
		coord_t y;
		scale_mask_t scale;
	} hit_t;

endpackage

`default_nettype wire

// File: haar_database.sv
`timescale 1ns/1ns
`default_nettype none

module haar_database import fd_classifier_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic i_start,
	output stage_bus_t o_stage
);

	stage_index_t idx;
	logic active;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active <= 1'b0;
			idx <= '0;
		end
		else if (i_start)
		begin
			active <= 1'b1;
			idx <= '0;
		end
		else if (active)
		begin
			if (idx == stage_index_t'(NUM_STAGES - 1))
				active <= 1'b0; // One pass per start
			idx <= idx + 1'b1;
		end
	end

	// Entry 0 appears in the cycle after the start pulse
	always_comb
	begin
		o_stage.entry = STAGE_TABLE[idx];
		o_stage.valid = active;
		o_stage.last = active && (idx == stage_index_t'(NUM_STAGES - 1));
	end

endmodule

`default_nettype wire

// File: result_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module result_buffer import fd_frame_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic i_clear,
	input wire logic i_write,
	input wire hit_t i_hit,
	input wire logic i_read_start,
	output hit_t o_hit,
	output logic o_hit_valid,
	output logic o_done,
	output result_count_t o_count
);

	hit_t mem [RESULT_DEPTH];
	result_count_t count; // Also the write pointer
	result_count_t rd_ptr;
	logic reading;
	logic full;

	assign full = count == result_count_t'(RESULT_DEPTH);

	always_ff @(posedge clk)
	begin
		if (i_write && !full)
			mem[result_addr_t'(count)] <= i_hit;
	end

	always_ff @(posedge clk)
	begin
		if (reset || i_clear)
		begin
			count <= '0;
			rd_ptr <= '0;
			reading <= 1'b0;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			if (i_write && !full)
				count <= count + 1'b1; // Hits past full are dropped
			if (i_read_start)
			begin
				rd_ptr <= '0;
				if (count == '0)
					o_done <= 1'b1;
				else
					reading <= 1'b1;
			end
			else if (reading)
			begin
				if (rd_ptr == count - 1'b1)
				begin
					reading <= 1'b0;
					o_done <= 1'b1;
				end
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_comb
	begin
		o_hit = mem[result_addr_t'(rd_ptr)];
		o_hit_valid = reading;
		o_count = count;
	end

endmodule

`default_nettype wire

// File: scale_inspector.sv
`timescale 1ns/1ns
`default_nettype none

module scale_inspector import fd_frame_pkg::*, fd_classifier_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic i_new_frame,
	input wire logic i_accept,
	input wire pixel_t i_pixel,
	input wire coord_t i_x,
	input wire coord_t i_y,
	input wire stage_bus_t i_stage,
	input wire stage_index_t i_scale_shift,
	output logic o_candidate
);

	pixel_t taps [WINDOW_TAPS]; // taps[0] is the newest sample
	coord_t grid_mask;
	score_t score;
	logic [2:0] fill; // Samples in the window, saturates at WINDOW_TAPS
	logic on_grid;
	logic sample;
	logic sampled; // Current pixel landed on this scale's grid
	logic pass_acc;
	logic stage_pass;

	always_comb
	begin
		grid_mask = (coord_t'(1) << i_scale_shift) - coord_t'(1);
		on_grid = ((i_x & grid_mask) == '0) && ((i_y & grid_mask) == '0);
		sample = i_accept && on_grid;
	end

	always_comb
	begin
		score = '0;
		for (int i = 0; i < WINDOW_TAPS; i++)
			score = score + score_t'($signed(i_stage.entry.weights[i]))
				* score_t'({4'b0000, taps[i]});
		stage_pass = score >= i_stage.entry.threshold;
	end

	// Start of a row drops the previous row's samples
	always_ff @(posedge clk)
	begin
		if (sample)
		begin
			taps[0] <= i_pixel;
			for (int i = 1; i < WINDOW_TAPS; i++)
				taps[i] <= (i_x == '0) ? '0 : taps[i-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset || i_new_frame)
		begin
			fill <= '0;
			sampled <= 1'b0;
			pass_acc <= 1'b0;
			o_candidate <= 1'b0;
		end
		else if (i_accept)
		begin
			sampled <= on_grid;
			pass_acc <= 1'b1;
			o_candidate <= 1'b0;
			if (on_grid)
			begin
				if (i_x == '0)
					fill <= 3'd1;
				else if (fill != 3'(WINDOW_TAPS))
					fill <= fill + 1'b1;
			end
		end
		else if (i_stage.valid)
		begin
			pass_acc <= pass_acc && stage_pass;
			if (i_stage.last)
				o_candidate <= sampled && (fill == 3'(WINDOW_TAPS)) && pass_acc && stage_pass;
		end
	end

endmodule

`default_nettype wire
